// ==== compile.f ====
+incdir+rtl
+incdir+dv
rtl/rv_decode_pkg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/operand_mux.sv
rtl/issue_ctrl.sv
rtl/decode_stage.sv
dv/tb_clk_gen.sv
dv/tb_decode_stage.sv

// ==== dv/tb_clk_gen.sv ====
/*
  Testbench clock and reset source.
  Free-running clock with a 4 ns period, reset held high for the first
  eight rising edges and released after them.
*/
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// ==== dv/decode_model.svh ====
/*
  Reference model for the decode stage testbench.
  Included inside the testbench module. Mirrors the register file and
  predicts control, operands, the load-use stall and the jalr target
  from the decode, forwarding and hazard rules.
*/
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

logic [`RVD_XLEN-1:0] model_regs [`RVD_NREGS];

function automatic rv_decode_pkg::dec_ctrl_t predict_ctrl(
  input rv_decode_pkg::inst_word_u w,
  input logic                      v
);
  rv_decode_pkg::dec_ctrl_t c;
  logic                     reg_form;
  c = '0;
  reg_form = 1'b0;
  case (w.r.opcode)
    7'b0110111: c.cls.lui = 1'b1;
    7'b0010111: c.cls.auipc = 1'b1;
    7'b1101111: c.cls.jal = 1'b1;
    7'b1100111: c.cls.jalr = 1'b1;
    7'b1100011: c.cls.branch = 1'b1;
    7'b0000011: c.cls.load = 1'b1;
    7'b0100011: c.cls.store = 1'b1;
    7'b0010011, 7'b0011011: c.cls.alu = 1'b1;
    7'b0110011, 7'b0111011: begin
      reg_form  = 1'b1;
      c.cls.alu = (w.r.funct7 == 7'h00) || (w.r.funct7 == 7'h20);
    end
    default: c = '0;
  endcase
  if (!v || (c.cls == '0)) begin
    c = '0;
    c.illegal = v;
    return c;
  end
  // the 32-bit variants all have opcode bit 3 set
  c.is_word = c.cls.alu && w.r.opcode[3];
  c.funct3  = w.r.funct3;
  if (c.cls.alu) begin
    c.alu_op = {w[30] && (reg_form || (w.r.funct3 == 3'b101)), w.r.funct3};
  end else if (c.cls.branch || c.cls.load || c.cls.store) begin
    c.alu_op = {1'b0, w.r.funct3};
  end
  c.rs1_rd = c.cls.alu || c.cls.branch || c.cls.load || c.cls.store || c.cls.jalr;
  c.rs2_rd = reg_form || c.cls.branch || c.cls.store;
  if ((c.cls.lui || c.cls.auipc || c.cls.jal || c.cls.jalr || c.cls.load || c.cls.alu)
      && (w.r.rd != '0)) begin
    c.rd_we = 1'b1;
    c.rd    = w.r.rd;
  end
  return c;
endfunction

function automatic logic [`RVD_XLEN-1:0] sext_i(input rv_decode_pkg::inst_word_u w);
  return {{(`RVD_XLEN-12){w.i.imm12[11]}}, w.i.imm12};
endfunction

// EX over MEM over the register file, wb written through
function automatic logic [`RVD_XLEN-1:0] forward_source(
  input logic [`RVD_REG_AW-1:0] addr,
  input rv_decode_pkg::id_ex_t  prev,
  input logic [`RVD_XLEN-1:0]   ex_res,
  input rv_decode_pkg::fwd_t    mem,
  input rv_decode_pkg::fwd_t    wr
);
  if (prev.valid && prev.ctrl.rd_we && (prev.ctrl.rd == addr)) begin
    return ex_res;
  end
  if (addr == '0) begin
    return '0;
  end
  if (mem.we && (mem.addr == addr)) begin
    return mem.data;
  end
  if (wr.we && (wr.addr == addr)) begin
    return wr.data;
  end
  return model_regs[addr];
endfunction

function automatic rv_decode_pkg::id_ex_t predict_entry(
  input rv_decode_pkg::inst_word_u w,
  input logic                      v,
  input logic [`RVD_XLEN-1:0]      w_pc,
  input rv_decode_pkg::dec_ctrl_t  c,
  input rv_decode_pkg::id_ex_t     prev,
  input logic [`RVD_XLEN-1:0]      ex_res,
  input rv_decode_pkg::fwd_t       mem,
  input rv_decode_pkg::fwd_t       wr
);
  rv_decode_pkg::id_ex_t e;
  logic [`RVD_XLEN-1:0]  s1;
  logic [`RVD_XLEN-1:0]  s2;
  logic [`RVD_XLEN-1:0]  u_imm;
  e = '0;
  s1 = forward_source(w.r.rs1, prev, ex_res, mem, wr);
  s2 = forward_source(w.r.rs2, prev, ex_res, mem, wr);
  u_imm = {{(`RVD_XLEN-32){w.u.imm20[19]}}, w.u.imm20, 12'b0};
  e.valid = v;
  e.ctrl  = c;
  e.pc    = w_pc;
  if (c.rs1_rd) begin
    e.op1 = s1;
  end else if (c.cls.auipc || c.cls.jal) begin
    e.op1 = w_pc;
  end
  if (c.rs2_rd) begin
    e.op2 = s2;
  end else if (c.cls.alu) begin
    e.op2 = sext_i(w);
  end else if (c.cls.lui || c.cls.auipc) begin
    e.op2 = u_imm;
  end else if (c.cls.jal || c.cls.jalr) begin
    e.op2 = w_pc;
  end
  if (c.cls.load) begin
    e.mem_off = w.i.imm12;
  end else if (c.cls.store) begin
    e.mem_off = {w.s.imm_hi, w.s.imm_lo};
  end
  return e;
endfunction

function automatic logic load_use_hazard(
  input rv_decode_pkg::inst_word_u w,
  input logic                      v,
  input rv_decode_pkg::dec_ctrl_t  c,
  input rv_decode_pkg::id_ex_t     prev
);
  logic pending;
  pending = prev.valid && prev.ctrl.cls.load && prev.ctrl.rd_we;
  return v && pending && ((c.rs1_rd && (w.r.rs1 == prev.ctrl.rd)) ||
                          (c.rs2_rd && (w.r.rs2 == prev.ctrl.rd)));
endfunction

function automatic logic [`RVD_XLEN-1:0] jalr_target(
  input rv_decode_pkg::inst_word_u w,
  input rv_decode_pkg::id_ex_t     prev,
  input logic [`RVD_XLEN-1:0]      ex_res,
  input rv_decode_pkg::fwd_t       mem,
  input rv_decode_pkg::fwd_t       wr
);
  logic [`RVD_XLEN-1:0] sum;
  sum = forward_source(w.r.rs1, prev, ex_res, mem, wr) + sext_i(w);
  return {sum[`RVD_XLEN-1:1], 1'b0};
endfunction

function automatic void apply_writeback(input rv_decode_pkg::fwd_t wr);
  if (wr.we && (wr.addr != '0)) begin
    model_regs[wr.addr] = wr.data;
  end
endfunction

function automatic void clear_model_regs();
  for (int i = 0; i < `RVD_NREGS; i++) begin
    model_regs[i] = '0;
  end
endfunction

`endif

// ==== dv/tb_decode_stage.sv ====
/*
  Testbench for the rv64 decode stage.
  Drives random instruction words and forwarding sources on the falling
  edge, predicts each ID/EX entry, stall and redirect with the included
  model, and compares them with the DUT. Ends with one line of counts.
*/
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module tb_decode_stage;

  localparam int SWEEP_WORDS  = 32;
  localparam int WIDE_WORDS   = 600;
  localparam int DENSE_WORDS  = 1200;
  localparam int HAZARD_WORDS = 600;
  localparam int TOTAL_WORDS  = SWEEP_WORDS + WIDE_WORDS + DENSE_WORDS + HAZARD_WORDS;
  // each word costs at most two cycles, plus reset, flushes and margin
  localparam int CYCLE_LIMIT  = 2 * TOTAL_WORDS + 8 + 64;

  logic                      clk;
  logic                      rst;
  logic                      inst_valid;
  logic [`RVD_XLEN-1:0]      pc;
  rv_decode_pkg::inst_word_u inst;
  logic [`RVD_XLEN-1:0]      ex_result;
  rv_decode_pkg::fwd_t       mem_fwd;
  rv_decode_pkg::fwd_t       wb;
  rv_decode_pkg::id_ex_t     id_ex;
  logic                      stall;
  logic                      redirect;
  logic [`RVD_XLEN-1:0]      redirect_pc;

  rv_decode_pkg::id_ex_t exp_entry;
  int errors;
  int checks;
  int tests;
  int stalls;
  int redirects;
  int err_mark;
  int cycle_count = 0;

`include "decode_model.svh"

  tb_clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(8)) u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  decode_stage UUT (
    .clk           (clk),
    .rst_i         (rst),
    .inst_valid_i  (inst_valid),
    .pc_i          (pc),
    .inst_i        (inst),
    .ex_result_i   (ex_result),
    .mem_fwd_i     (mem_fwd),
    .wb_i          (wb),
    .id_ex_o       (id_ex),
    .stall_o       (stall),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc)
  );

  task automatic check_ctrl(input string name, input rv_decode_pkg::dec_ctrl_t exp,
                            input rv_decode_pkg::dec_ctrl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s ctrl expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_entry(input string name, input rv_decode_pkg::id_ex_t exp,
                             input rv_decode_pkg::id_ex_t act);
    checks++;
    if (act.valid !== exp.valid) begin
      errors++;
      $display("CHECK FAILED %s valid expected %b actual %b", name, exp.valid, act.valid);
    end else if (exp.valid) begin
      if (act.pc !== exp.pc) begin
        errors++;
        $display("CHECK FAILED %s pc expected %h actual %h", name, exp.pc, act.pc);
      end
      if (act.op1 !== exp.op1) begin
        errors++;
        $display("CHECK FAILED %s op1 expected %h actual %h", name, exp.op1, act.op1);
      end
      if (act.op2 !== exp.op2) begin
        errors++;
        $display("CHECK FAILED %s op2 expected %h actual %h", name, exp.op2, act.op2);
      end
      if (act.mem_off !== exp.mem_off) begin
        errors++;
        $display("CHECK FAILED %s mem_off expected %h actual %h", name, exp.mem_off,
                 act.mem_off);
      end
    end
    check_ctrl(name, exp.ctrl, act.ctrl);
  endtask

  task automatic check_flags(input string name, input logic exp_stall, input logic exp_redir,
                             input logic [`RVD_XLEN-1:0] exp_pc, input logic act_stall,
                             input logic act_redir, input logic [`RVD_XLEN-1:0] act_pc);
    checks++;
    if ((act_stall !== exp_stall) || (act_redir !== exp_redir)) begin
      errors++;
      $display("CHECK FAILED %s stall/redirect expected %b%b actual %b%b", name,
               exp_stall, exp_redir, act_stall, act_redir);
    end else if (exp_redir && (act_pc !== exp_pc)) begin
      errors++;
      $display("CHECK FAILED %s redirect_pc expected %h actual %h", name, exp_pc, act_pc);
    end
  endtask

  function automatic logic [`RVD_REG_AW-1:0] pick_reg(input int hi);
    logic [31:0] r;
    r = $urandom_range(hi, 0);
    return r[`RVD_REG_AW-1:0];
  endfunction

  function automatic rv_decode_pkg::fwd_t random_fwd(input int reg_hi, input int pct);
    rv_decode_pkg::fwd_t f;
    f.we   = ($urandom_range(99, 0) < pct);
    f.addr = pick_reg(reg_hi);
    f.data = {$urandom, $urandom};
    return f;
  endfunction

  // loads weighted double so load-use shows up often
  function automatic rv_decode_pkg::inst_word_u random_word(input int reg_hi);
    rv_decode_pkg::inst_word_u w;
    logic [31:0]               kind;
    w = $urandom;
    kind = $urandom_range(13, 0);
    w.r.rd = pick_reg(reg_hi);
    case (kind)
      0: w.r.opcode = 7'b0110111;
      1: w.r.opcode = 7'b0010111;
      2: w.r.opcode = 7'b1101111;
      3: w.r.opcode = 7'b1100111;
      4: w.r.opcode = 7'b1100011;
      5, 12: w.r.opcode = 7'b0000011;
      6: w.r.opcode = 7'b0100011;
      7: w.r.opcode = 7'b0010011;
      8: w.r.opcode = 7'b0011011;
      9, 10: begin
        w.r.opcode = (kind == 9) ? 7'b0110011 : 7'b0111011;
        w.r.funct7 = ($urandom_range(1, 0) != 0) ? 7'h20 : 7'h00;
      end
      11: begin
        // M extension, not decoded
        w.r.opcode = ($urandom_range(1, 0) != 0) ? 7'b0110011 : 7'b0111011;
        w.r.funct7 = 7'h01;
      end
      default: begin
        case ($urandom_range(4, 0))
          0: w.r.opcode = 7'b1110011;
          1: w.r.opcode = 7'b0001111;
          2: w.r.opcode = 7'b0101111;
          3: w.r.opcode = 7'b1010011;
          default: w.r.opcode = 7'b0000000;
        endcase
      end
    endcase
    if ((kind >= 3) && (kind <= 12)) begin
      w.r.rs1 = pick_reg(reg_hi);
    end
    if ((kind == 4) || (kind == 6) || ((kind >= 9) && (kind <= 11))) begin
      w.r.rs2 = pick_reg(reg_hi);
    end
    return w;
  endfunction

  // called on a falling edge, returns on the next one
  task automatic step(input string name, input rv_decode_pkg::inst_word_u w, input logic v,
                      input logic [`RVD_XLEN-1:0] w_pc, input logic [`RVD_XLEN-1:0] ex_res,
                      input rv_decode_pkg::fwd_t mem, input rv_decode_pkg::fwd_t wr,
                      output logic held);
    rv_decode_pkg::dec_ctrl_t c;
    rv_decode_pkg::id_ex_t    next_entry;
    logic                     exp_stall;
    logic                     exp_redir;
    logic [`RVD_XLEN-1:0]     exp_target;

    check_entry(name, exp_entry, id_ex);
    inst_valid = v;
    pc         = w_pc;
    inst       = w;
    ex_result  = ex_res;
    mem_fwd    = mem;
    wb         = wr;
    #1;
    c          = predict_ctrl(w, v);
    next_entry = predict_entry(w, v, w_pc, c, exp_entry, ex_res, mem, wr);
    exp_stall  = load_use_hazard(w, v, c, exp_entry);
    exp_redir  = v && c.cls.jalr && !exp_stall;
    exp_target = jalr_target(w, exp_entry, ex_res, mem, wr);
    check_flags(name, exp_stall, exp_redir, exp_target, stall, redirect, redirect_pc);
    if (exp_stall) begin
      stalls++;
      exp_entry = '0;
    end else begin
      exp_entry = next_entry;
    end
    if (exp_redir) begin
      redirects++;
    end
    apply_writeback(wr);
    held = exp_stall;
    @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int words, input int n_stall,
                             input int n_redir);
    tests++;
    $display("test %s done: %0d words, %0d stalls, %0d redirects, %0d errors", name,
             words, n_stall, n_redir, errors - err_mark);
    err_mark = errors;
  endtask

  // a valid word reading x0 right after reset, stalls only on a stale ID/EX load
  task automatic check_reset(input string name);
    rv_decode_pkg::inst_word_u w;
    rv_decode_pkg::fwd_t       idle;
    logic                      held;
    w = '0;
    w.r.opcode = 7'b0110011;
    idle = '0;
    step(name, w, 1'b1, 64'h800, '0, idle, idle, held);
    finish_test(name, 1, 0, 0);
  endtask

  // reads every register with nothing forwarded, all must be zero
  task automatic sweep_zero_regs(input string name);
    rv_decode_pkg::inst_word_u w;
    rv_decode_pkg::fwd_t       idle;
    logic [`RVD_XLEN-1:0]      w_pc;
    logic                      held;
    idle = '0;
    w_pc = 64'h1000;
    for (int k = 0; k < SWEEP_WORDS; k++) begin
      w = '0;
      w.r.opcode = 7'b0110011;
      w.r.rs1 = k[4:0];
      w.r.rs2 = 5'd31 - k[4:0];
      step(name, w, 1'b1, w_pc, {$urandom, $urandom}, idle, idle, held);
      w_pc = w_pc + 64'd4;
    end
    step(name, '0, 1'b0, '0, '0, idle, idle, held);
    finish_test(name, SWEEP_WORDS, 0, 0);
  endtask

  task automatic run_random(input string name, input int words, input int reg_hi,
                            input int fwd_pct, input logic want_hazards);
    rv_decode_pkg::inst_word_u w;
    logic                      v;
    logic                      held;
    logic [`RVD_XLEN-1:0]      w_pc;
    int                        issued;
    int                        stall0;
    int                        redir0;
    w = '0;
    v = 1'b0;
    held = 1'b0;
    w_pc = '0;
    issued = 0;
    stall0 = stalls;
    redir0 = redirects;
    while (issued < words) begin
      if (!held) begin
        w    = random_word(reg_hi);
        v    = ($urandom_range(9, 0) != 0);
        w_pc = {$urandom, $urandom} & ~64'h3;
      end
      step(name, w, v, w_pc, {$urandom, $urandom}, random_fwd(reg_hi, fwd_pct),
           random_fwd(reg_hi, fwd_pct), held);
      if (!held) begin
        issued++;
      end
    end
    step(name, '0, 1'b0, '0, '0, '0, '0, held);
    if (want_hazards && ((stalls == stall0) || (redirects == redir0))) begin
      errors++;
      $display("%s never saw both a load-use stall and a jalr redirect", name);
    end
    finish_test(name, words, stalls - stall0, redirects - redir0);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h8b431735));
    inst_valid = 1'b0;
    pc         = '0;
    inst       = '0;
    ex_result  = '0;
    mem_fwd    = '0;
    wb         = '0;
    exp_entry  = '0;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    stalls     = 0;
    redirects  = 0;
    err_mark   = 0;
    clear_model_regs();
    @(negedge rst);
    @(negedge clk);
    check_reset("reset_state");
    sweep_zero_regs("reg_zero_sweep");
    run_random("decode_wide", WIDE_WORDS, 31, 20, 1'b0);
    run_random("forward_dense", DENSE_WORDS, 3, 70, 1'b1);
    run_random("hazard_dense", HAZARD_WORDS, 1, 50, 1'b1);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/decode_stage.sv ====
/*
  Decode stage top level.
  Connects the decoder, the register file, the operand build and the
  issue control. A word presented at one edge is in ID/EX after the next;
  stall and redirect are combinational with the word.
*/
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module decode_stage (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      inst_valid_i,
  input  logic [`RVD_XLEN-1:0]      pc_i,
  input  rv_decode_pkg::inst_word_u inst_i,
  input  logic [`RVD_XLEN-1:0]      ex_result_i,
  input  rv_decode_pkg::fwd_t       mem_fwd_i,
  input  rv_decode_pkg::fwd_t       wb_i,
  output rv_decode_pkg::id_ex_t     id_ex_o,
  output logic                      stall_o,
  output logic                      redirect_o,
  output logic [`RVD_XLEN-1:0]      redirect_pc_o
);

  rv_decode_pkg::dec_ctrl_t ctrl;
  logic [`RVD_XLEN-1:0]     rf1;
  logic [`RVD_XLEN-1:0]     rf2;
  logic [`RVD_XLEN-1:0]     op1;
  logic [`RVD_XLEN-1:0]     op2;
  logic [11:0]              mem_off;
  logic [`RVD_XLEN-1:0]     jalr_pc;

  inst_decoder u_dec (
    .inst_i  (inst_i),
    .valid_i (inst_valid_i),
    .ctrl_o  (ctrl)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst_i    (rst_i),
    .raddr1_i (inst_i.r.rs1),
    .raddr2_i (inst_i.r.rs2),
    .rdata1_o (rf1),
    .rdata2_o (rf2),
    .wb_i     (wb_i)
  );

  // the entry in ID/EX is the EX forward source
  operand_mux u_opmux (
    .inst_i      (inst_i),
    .pc_i        (pc_i),
    .ctrl_i      (ctrl),
    .rf1_i       (rf1),
    .rf2_i       (rf2),
    .ex_entry_i  (id_ex_o),
    .ex_result_i (ex_result_i),
    .mem_fwd_i   (mem_fwd_i),
    .op1_o       (op1),
    .op2_o       (op2),
    .mem_off_o   (mem_off),
    .jalr_pc_o   (jalr_pc)
  );

  issue_ctrl u_issue (
    .clk           (clk),
    .rst_i         (rst_i),
    .valid_i       (inst_valid_i),
    .pc_i          (pc_i),
    .ctrl_i        (ctrl),
    .rs1_i         (inst_i.r.rs1),
    .rs2_i         (inst_i.r.rs2),
    .op1_i         (op1),
    .op2_i         (op2),
    .mem_off_i     (mem_off),
    .jalr_pc_i     (jalr_pc),
    .id_ex_o       (id_ex_o),
    .stall_o       (stall_o),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

endmodule

// ==== rtl/inst_decoder.sv ====
/*
  Combinational decode of one instruction word into the control struct.
  Covers the RV64I integer subset; anything else comes out flagged illegal
  with every enable clear. An invalid slot gives an all-zero struct.
*/
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module inst_decoder (
  input  rv_decode_pkg::inst_word_u inst_i,
  input  logic                      valid_i,
  output rv_decode_pkg::dec_ctrl_t  ctrl_o
);

  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMMW = 7'b0011011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OPW     = 7'b0111011;

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [`RVD_REG_AW-1:0] rd;
  logic                   f7_ok;
  logic                   shift_r;

  assign opcode  = inst_i.r.opcode;
  assign funct3  = inst_i.r.funct3;
  assign funct7  = inst_i.r.funct7;
  assign rd      = inst_i.r.rd;
  // only base encodings, the M extension is not decoded
  assign f7_ok   = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
  assign shift_r = (funct3 == 3'b101);

  always_comb begin
    rv_decode_pkg::inst_class_t cls;
    logic                       is_word;
    logic                       reg_op;
    logic                       mod_bit;

    cls     = '0;
    is_word = 1'b0;
    reg_op  = 1'b0;

    case (opcode)
      OPC_LUI:     cls.lui    = 1'b1;
      OPC_AUIPC:   cls.auipc  = 1'b1;
      OPC_JAL:     cls.jal    = 1'b1;
      OPC_JALR:    cls.jalr   = 1'b1;
      OPC_BRANCH:  cls.branch = 1'b1;
      OPC_LOAD:    cls.load   = 1'b1;
      OPC_STORE:   cls.store  = 1'b1;
      OPC_OP_IMM:  cls.alu    = 1'b1;
      OPC_OP_IMMW: begin
        cls.alu = 1'b1;
        is_word = 1'b1;
      end
      OPC_OP: begin
        cls.alu = f7_ok;
        reg_op  = 1'b1;
      end
      OPC_OPW: begin
        cls.alu = f7_ok;
        reg_op  = 1'b1;
        is_word = 1'b1;
      end
      default: cls = '0;
    endcase

    // inst[30] picks sub/sra, or srai on the immediate forms
    mod_bit = (reg_op || shift_r) && funct7[5];

    ctrl_o         = '0;
    ctrl_o.cls     = cls;
    ctrl_o.is_word = is_word;
    ctrl_o.funct3  = funct3;
    if (cls.alu) begin
      ctrl_o.alu_op = {mod_bit, funct3};
    end else if (cls.branch || cls.load || cls.store) begin
      ctrl_o.alu_op = {1'b0, funct3};
    end
    ctrl_o.rs1_rd = cls.alu || cls.branch || cls.load || cls.store || cls.jalr;
    ctrl_o.rs2_rd = (cls.alu && reg_op) || cls.branch || cls.store;
    ctrl_o.rd_we  = (cls.lui || cls.auipc || cls.jal || cls.jalr || cls.load || cls.alu)
                    && (rd != '0);
    ctrl_o.rd     = ctrl_o.rd_we ? rd : '0;

    // unsupported or empty slot, nothing enabled
    if (!valid_i || (cls == '0)) begin
      ctrl_o         = '0;
      ctrl_o.illegal = valid_i;
    end
  end

  always_comb begin
    cls_onehot_a: assert ($onehot0(ctrl_o.cls))
      else $error("decoder class is not one-hot");
  end

endmodule

// ==== rtl/issue_ctrl.sv ====
/*
  ID/EX register and issue control.
  Checks the current word against the load held in ID/EX, loads a bubble
  while that load is still pending, and raises the jalr redirect for a
  jalr that issues this cycle.
*/
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module issue_ctrl (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     valid_i,
  input  logic [`RVD_XLEN-1:0]     pc_i,
  input  rv_decode_pkg::dec_ctrl_t ctrl_i,
  input  logic [`RVD_REG_AW-1:0]   rs1_i,
  input  logic [`RVD_REG_AW-1:0]   rs2_i,
  input  logic [`RVD_XLEN-1:0]     op1_i,
  input  logic [`RVD_XLEN-1:0]     op2_i,
  input  logic [11:0]              mem_off_i,
  input  logic [`RVD_XLEN-1:0]     jalr_pc_i,
  output rv_decode_pkg::id_ex_t    id_ex_o,
  output logic                     stall_o,
  output logic                     redirect_o,
  output logic [`RVD_XLEN-1:0]     redirect_pc_o
);

  rv_decode_pkg::id_ex_t entry_q;
  logic                  ld_pending;
  logic                  hit1;
  logic                  hit2;

  // load in EX whose data is not there yet
  assign ld_pending = entry_q.valid && entry_q.ctrl.cls.load && entry_q.ctrl.rd_we;
  assign hit1       = ctrl_i.rs1_rd && (rs1_i == entry_q.ctrl.rd);
  assign hit2       = ctrl_i.rs2_rd && (rs2_i == entry_q.ctrl.rd);
  assign stall_o    = valid_i && ld_pending && (hit1 || hit2);

  assign redirect_o    = valid_i && ctrl_i.cls.jalr && !stall_o;
  assign redirect_pc_o = jalr_pc_i;

  always_ff @(posedge clk) begin
    entry_q.pc      <= pc_i;
    entry_q.op1     <= op1_i;
    entry_q.op2     <= op2_i;
    entry_q.mem_off <= mem_off_i;
    if (rst_i) begin
      entry_q.valid <= 1'b0;
      entry_q.ctrl  <= '0;
    end else if (stall_o) begin
      // bubble, the word is decoded again next cycle
      entry_q.valid <= 1'b0;
      entry_q.ctrl  <= '0;
    end else begin
      entry_q.valid <= valid_i;
      entry_q.ctrl  <= ctrl_i;
    end
  end

  assign id_ex_o = entry_q;

  stall_redirect_excl_a: assert property (@(posedge clk) disable iff (rst_i)
    !(stall_o && redirect_o))
    else $error("redirect raised during a stall");

endmodule

// ==== rtl/operand_mux.sv ====
/*
  Operand build for the decode stage.
  Makes the immediates from the word, forwards each source from EX, then
  MEM, then the register file, and picks op1, op2, the memory offset and
  the jalr target. Purely combinational.
*/
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module operand_mux (
  input  rv_decode_pkg::inst_word_u inst_i,
  input  logic [`RVD_XLEN-1:0]      pc_i,
  input  rv_decode_pkg::dec_ctrl_t  ctrl_i,
  input  logic [`RVD_XLEN-1:0]      rf1_i,
  input  logic [`RVD_XLEN-1:0]      rf2_i,
  input  rv_decode_pkg::id_ex_t     ex_entry_i,
  input  logic [`RVD_XLEN-1:0]      ex_result_i,
  input  rv_decode_pkg::fwd_t       mem_fwd_i,
  output logic [`RVD_XLEN-1:0]      op1_o,
  output logic [`RVD_XLEN-1:0]      op2_o,
  output logic [11:0]               mem_off_o,
  output logic [`RVD_XLEN-1:0]      jalr_pc_o
);

  logic [`RVD_XLEN-1:0] i_imm;
  logic [`RVD_XLEN-1:0] u_imm;
  logic [11:0]          s_imm;
  logic [`RVD_XLEN-1:0] src1;
  logic [`RVD_XLEN-1:0] src2;
  logic [`RVD_XLEN-1:0] jalr_sum;

  assign i_imm = {{(`RVD_XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
  assign u_imm = {{(`RVD_XLEN-32){inst_i.u.imm20[19]}}, inst_i.u.imm20, 12'b0};
  assign s_imm = {inst_i.s.imm_hi, inst_i.s.imm_lo};

  // youngest producer wins
  function automatic logic [`RVD_XLEN-1:0] fwd_pick(
    input logic [`RVD_REG_AW-1:0] addr,
    input logic [`RVD_XLEN-1:0]   rf_data
  );
    if (ex_entry_i.valid && ex_entry_i.ctrl.rd_we && (ex_entry_i.ctrl.rd == addr)) begin
      return ex_result_i;
    end else if (mem_fwd_i.we && (mem_fwd_i.addr == addr) && (addr != '0)) begin
      // a stray MEM write to x0 must not leak into reads
      return mem_fwd_i.data;
    end
    return rf_data;
  endfunction

  always_comb begin
    src1 = fwd_pick(inst_i.r.rs1, rf1_i);
    src2 = fwd_pick(inst_i.r.rs2, rf2_i);
  end

  always_comb begin
    if (ctrl_i.rs1_rd) begin
      op1_o = src1;
    end else if (ctrl_i.cls.auipc || ctrl_i.cls.jal) begin
      op1_o = pc_i;
    end else begin
      op1_o = '0;
    end
  end

  always_comb begin
    if (ctrl_i.rs2_rd) begin
      op2_o = src2;
    end else if (ctrl_i.cls.alu) begin
      op2_o = i_imm;
    end else if (ctrl_i.cls.lui || ctrl_i.cls.auipc) begin
      op2_o = u_imm;
    end else if (ctrl_i.cls.jal || ctrl_i.cls.jalr) begin
      // link value is formed in EX from the pc
      op2_o = pc_i;
    end else begin
      op2_o = '0;
    end
  end

  assign mem_off_o = ctrl_i.cls.load  ? inst_i.i.imm12 :
                     ctrl_i.cls.store ? s_imm : 12'b0;

  assign jalr_sum  = src1 + i_imm;
  assign jalr_pc_o = {jalr_sum[`RVD_XLEN-1:1], 1'b0};

endmodule

// ==== rtl/reg_file.sv ====
/*
  Integer register file for the decode stage.
  Two combinational read ports and one write port from writeback.
  A read of the register being written this cycle sees the new value.
*/
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic [`RVD_REG_AW-1:0] raddr1_i,
  input  logic [`RVD_REG_AW-1:0] raddr2_i,
  output logic [`RVD_XLEN-1:0]   rdata1_o,
  output logic [`RVD_XLEN-1:0]   rdata2_o,
  input  rv_decode_pkg::fwd_t    wb_i
);

  // x0 has no storage
  logic [`RVD_XLEN-1:0] regs_q [1:`RVD_NREGS-1];
  logic                 wr_en;

  assign wr_en = wb_i.we && (wb_i.addr != '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < `RVD_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wb_i.addr] <= wb_i.data;
    end
  end

  function automatic logic [`RVD_XLEN-1:0] read_port(input logic [`RVD_REG_AW-1:0] addr);
    if (addr == '0) begin
      return '0;
    end else if (wr_en && (wb_i.addr == addr)) begin
      return wb_i.data;
    end
    return regs_q[addr];
  endfunction

  always_comb begin
    rdata1_o = read_port(raddr1_i);
    rdata2_o = read_port(raddr2_i);
  end

  x0_zero_a: assert property (@(posedge clk)
    ((raddr1_i != '0) || (rdata1_o == '0)) && ((raddr2_i != '0) || (rdata2_o == '0)))
    else $error("x0 read back nonzero");

endmodule

// ==== rtl/rv_decode_cfg.svh ====
/*
  Build-time sizes for the rv64 decode stage.
  Included by the package and by every module that sizes a port or a
  register from these values.
*/
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// data and pc width, one word
`define RVD_XLEN 64

// instruction word width
`define RVD_INST_W 32

// register address width
`define RVD_REG_AW 5

// architectural register count, x0 included
`define RVD_NREGS 32

// width of the alu code handed to execute
// funct3 plus one modifier bit
`define RVD_ALU_OP_W 4

`endif

// ==== rtl/rv_decode_pkg.sv ====
/*
  Types shared by the decode stage blocks and its testbench.
  The instruction word is a union of the base formats; the control,
  forward and ID/EX structs travel between the modules.
*/
`include "rv_decode_cfg.svh"

package rv_decode_pkg;

  typedef struct packed {
    logic [6:0]             funct7;
    logic [`RVD_REG_AW-1:0] rs2;
    logic [`RVD_REG_AW-1:0] rs1;
    logic [2:0]             funct3;
    logic [`RVD_REG_AW-1:0] rd;
    logic [6:0]             opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]            imm12;
    logic [`RVD_REG_AW-1:0] rs1;
    logic [2:0]             funct3;
    logic [`RVD_REG_AW-1:0] rd;
    logic [6:0]             opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]             imm_hi;
    logic [`RVD_REG_AW-1:0] rs2;
    logic [`RVD_REG_AW-1:0] rs1;
    logic [2:0]             funct3;
    logic [4:0]             imm_lo;
    logic [6:0]             opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0]            imm20;
    logic [`RVD_REG_AW-1:0] rd;
    logic [6:0]             opcode;
  } u_fmt_t;

  // one 32-bit word, four views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
  } inst_word_u;

  // one-hot, all zero for an unsupported word
  typedef struct packed {
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic alu;
  } inst_class_t;

  typedef struct packed {
    inst_class_t              cls;
    logic                     is_word;
    logic [`RVD_ALU_OP_W-1:0] alu_op;
    logic                     rs1_rd;
    logic                     rs2_rd;
    logic                     rd_we;
    logic [`RVD_REG_AW-1:0]   rd;
    logic [2:0]               funct3;
    logic                     illegal;
  } dec_ctrl_t;

  typedef struct packed {
    logic                   we;
    logic [`RVD_REG_AW-1:0] addr;
    logic [`RVD_XLEN-1:0]   data;
  } fwd_t;

  typedef struct packed {
    logic                 valid;
    dec_ctrl_t            ctrl;
    logic [`RVD_XLEN-1:0] pc;
    logic [`RVD_XLEN-1:0] op1;
    logic [`RVD_XLEN-1:0] op2;
    logic [11:0]          mem_off;
  } id_ex_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_decode_stage -o tb_decode_stage || exit 1

result=$(./obj_dir/tb_decode_stage 2>&1)
echo "$result"
echo "$result" | grep -qx "TESTS PASSED" && exit 0 || exit 1
